/* kd_pkg.sv */
/*
 kd-tree search package
 tree shape, patch layout and config bus map shared by the
 search engine and its testbench
*/
`default_nettype none

package kd_pkg;

    // one patch component, also the median width
    localparam int COMP_WIDTH = 11;
    localparam int NUM_DIMS = 5;
    localparam int PATCH_WIDTH = COMP_WIDTH * NUM_DIMS;

    // split dimension lives in the low bits of the high half
    localparam int DIM_WIDTH = 3;

    // node word: median in [10:0], dimension field in [21:11]
    localparam int NODE_WIDTH = 2 * COMP_WIDTH;

    // six internal levels, heap numbered from the root
    localparam int TREE_DEPTH = 6;
    localparam int NUM_NODES = (1 << TREE_DEPTH) - 1;
    localparam int NODE_ADDR_WIDTH = TREE_DEPTH;
    localparam int NUM_LEAVES = 1 << TREE_DEPTH;
    localparam int LEAF_WIDTH = TREE_DEPTH;

    // input stage plus one register per level
    localparam int SEARCH_LATENCY = TREE_DEPTH + 1;

    // config bus
    localparam int WB_WIDTH = 32;
    localparam logic [WB_WIDTH-1:0] CFG_BASE = 32'h0000_1000;
    // two 32-bit words per node, low half first
    localparam int NODE_STRIDE = 8;
    localparam logic [WB_WIDTH-1:0] CFG_SPAN = WB_WIDTH'(NUM_NODES * NODE_STRIDE);

endpackage

`default_nettype wire

/* kd_internal_node.sv */
/*
 kd-tree internal node
 holds one split (dimension and median) and routes the valid bit of
 each query lane to its left or right child
*/
`timescale 1ns/1ps
`default_nettype none

module kd_internal_node (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           wr_en_i,
    input  wire  [kd_pkg::NODE_WIDTH-1:0]  wr_data_i,
    input  wire                           valid_i,
    input  wire                           valid_two_i,
    input  wire  [kd_pkg::PATCH_WIDTH-1:0] patch_i,
    input  wire  [kd_pkg::PATCH_WIDTH-1:0] patch_two_i,
    output logic                          valid_left_o,
    output logic                          valid_right_o,
    output logic                          valid_left_two_o,
    output logic                          valid_right_two_o,
    output logic [kd_pkg::NODE_WIDTH-1:0]  rd_data_o
);
    import kd_pkg::*;

    logic [NODE_WIDTH-1:0] node_q;
    logic [DIM_WIDTH-1:0]  split_dim;
    logic [COMP_WIDTH-1:0] median;
    logic [COMP_WIDTH-1:0] comp;
    logic [COMP_WIDTH-1:0] comp_two;
    logic                  go_right;
    logic                  go_right_two;

    // split storage, empty node compares against zero on dim 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            node_q <= '0;
        end else if (wr_en_i) begin
            node_q <= wr_data_i;
        end
    end

    assign median = node_q[COMP_WIDTH-1:0];
    assign split_dim = node_q[COMP_WIDTH +: DIM_WIDTH];
    assign rd_data_o = node_q;

    // component select per lane
    // dims 5..7 fall back to component 0
    always_comb begin
        comp = patch_i[0 +: COMP_WIDTH];
        comp_two = patch_two_i[0 +: COMP_WIDTH];
        for (int d = 1; d < NUM_DIMS; d++) begin
            if (split_dim == DIM_WIDTH'(d)) begin
                comp = patch_i[d*COMP_WIDTH +: COMP_WIDTH];
                comp_two = patch_two_i[d*COMP_WIDTH +: COMP_WIDTH];
            end
        end
    end

    // strictly greater goes right, ties go left
    assign go_right = comp > median;
    assign go_right_two = comp_two > median;

    assign valid_left_o = valid_i & ~go_right;
    assign valid_right_o = valid_i & go_right;
    assign valid_left_two_o = valid_two_i & ~go_right_two;
    assign valid_right_two_o = valid_two_i & go_right_two;

endmodule

`default_nettype wire

/* kd_node_tree.sv */
/*
 kd-tree node array
 63 internal nodes in six levels with a patch and valid pipeline per
 lane, one level per clock, and a one-hot to index encoder per lane
 at the leaf level. node storage is written and read by node number
*/
`timescale 1ns/1ps
`default_nettype none

module kd_node_tree (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               node_wr_en_i,
    input  wire  [kd_pkg::NODE_ADDR_WIDTH-1:0] node_wr_addr_i,
    input  wire  [kd_pkg::NODE_WIDTH-1:0]      node_wr_data_i,
    input  wire  [kd_pkg::NODE_ADDR_WIDTH-1:0] node_rd_addr_i,
    input  wire                               query_valid_i,
    input  wire  [kd_pkg::PATCH_WIDTH-1:0]     query_i,
    input  wire                               query_two_valid_i,
    input  wire  [kd_pkg::PATCH_WIDTH-1:0]     query_two_i,
    output logic [kd_pkg::NODE_WIDTH-1:0]      node_rd_data_o,
    output logic                              leaf_valid_o,
    output logic [kd_pkg::LEAF_WIDTH-1:0]      leaf_index_o,
    output logic                              leaf_two_valid_o,
    output logic [kd_pkg::LEAF_WIDTH-1:0]      leaf_two_index_o
);
    import kd_pkg::*;

    // heap slots: nodes 0..62, leaves 63..126
    localparam int NUM_SLOTS = 2 * NUM_NODES + 1;
    localparam int LEAF_BASE = NUM_NODES;

    // patch seen by each level, index = level
    logic [PATCH_WIDTH-1:0] patch_q [TREE_DEPTH];
    logic [PATCH_WIDTH-1:0] patch_two_q [TREE_DEPTH];

    // registered valid per heap slot, slot 0 is the root input stage
    logic [NUM_SLOTS-1:0] valid_q;
    logic [NUM_SLOTS-1:0] valid_two_q;

    // child valids from the node outputs, slot 2n+1 left and 2n+2 right
    logic [NUM_SLOTS-1:1] child_valid;
    logic [NUM_SLOTS-1:1] child_valid_two;

    logic [NODE_WIDTH-1:0] node_rd [NUM_NODES];

    logic [NUM_LEAVES-1:0] leaf_vec;
    logic [NUM_LEAVES-1:0] leaf_vec_two;

    // one-hot leaf vector to index, OR of set positions
    function automatic logic [LEAF_WIDTH-1:0] encode_leaf(
        input logic [NUM_LEAVES-1:0] onehot
    );
        logic [LEAF_WIDTH-1:0] idx;
        idx = '0;
        for (int k = 0; k < NUM_LEAVES; k++) begin
            if (onehot[k]) begin
                idx = idx | LEAF_WIDTH'(k);
            end
        end
        return idx;
    endfunction

    // patch pipeline, level l holds the patch that entered l cycles ago
    always_ff @(posedge clk) begin
        patch_q[0] <= query_i;
        patch_two_q[0] <= query_two_i;
        for (int l = 1; l < TREE_DEPTH; l++) begin
            patch_q[l] <= patch_q[l-1];
            patch_two_q[l] <= patch_two_q[l-1];
        end
    end

    // valid pipeline, root takes the query strobe
    // every other slot takes its parent's routed valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            valid_two_q <= '0;
        end else begin
            valid_q <= {child_valid, query_valid_i};
            valid_two_q <= {child_valid_two, query_two_valid_i};
        end
    end

    for (genvar lvl = 0; lvl < TREE_DEPTH; lvl++) begin : g_lvl
        for (genvar pos = 0; pos < (1 << lvl); pos++) begin : g_pos
            localparam int N = (1 << lvl) - 1 + pos;

            kd_internal_node u_node (
                .clk               (clk),
                .rst_n             (rst_n),
                .wr_en_i           (node_wr_en_i && (node_wr_addr_i == NODE_ADDR_WIDTH'(N))),
                .wr_data_i         (node_wr_data_i),
                .valid_i           (valid_q[N]),
                .valid_two_i       (valid_two_q[N]),
                .patch_i           (patch_q[lvl]),
                .patch_two_i       (patch_two_q[lvl]),
                .valid_left_o      (child_valid[2*N+1]),
                .valid_right_o     (child_valid[2*N+2]),
                .valid_left_two_o  (child_valid_two[2*N+1]),
                .valid_right_two_o (child_valid_two[2*N+2]),
                .rd_data_o         (node_rd[N])
            );
        end
    end

    // node read back, slot 63 has no node
    always_comb begin
        node_rd_data_o = '0;
        if (node_rd_addr_i < NODE_ADDR_WIDTH'(NUM_NODES)) begin
            node_rd_data_o = node_rd[node_rd_addr_i];
        end
    end

    // leaf slot order matches the path bits, root decision is the msb
    assign leaf_vec = valid_q[NUM_SLOTS-1:LEAF_BASE];
    assign leaf_vec_two = valid_two_q[NUM_SLOTS-1:LEAF_BASE];

    assign leaf_valid_o = |leaf_vec;
    assign leaf_index_o = encode_leaf(leaf_vec);
    assign leaf_two_valid_o = |leaf_vec_two;
    assign leaf_two_index_o = encode_leaf(leaf_vec_two);

endmodule

`default_nettype wire

/* kd_node_loader.sv */
/*
 kd-tree node loader
 picks the node write source: a streaming port with a wrapping
 counter, or a wishbone slave writing nodes in two 11-bit halves.
 the slave acknowledges every request one clock later
*/
`timescale 1ns/1ps
`default_nettype none

module kd_node_loader (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               bus_mode_i,
    input  wire                               load_valid_i,
    input  wire  [kd_pkg::NODE_WIDTH-1:0]      load_data_i,
    input  wire                               wbs_cyc_i,
    input  wire                               wbs_stb_i,
    input  wire                               wbs_we_i,
    input  wire  [kd_pkg::WB_WIDTH-1:0]        wbs_adr_i,
    input  wire  [kd_pkg::WB_WIDTH-1:0]        wbs_dat_i,
    input  wire  [kd_pkg::NODE_WIDTH-1:0]      node_rd_data_i,
    output logic                              wbs_ack_o,
    output logic [kd_pkg::WB_WIDTH-1:0]        wbs_dat_o,
    output logic                              node_wr_en_o,
    output logic [kd_pkg::NODE_ADDR_WIDTH-1:0] node_wr_addr_o,
    output logic [kd_pkg::NODE_WIDTH-1:0]      node_wr_data_o,
    output logic [kd_pkg::NODE_ADDR_WIDTH-1:0] node_rd_addr_o
);
    import kd_pkg::*;

    logic [NODE_ADDR_WIDTH-1:0] wr_cnt_q;
    logic                       stream_we;
    logic                       bus_req;
    logic                       bus_ok;
    logic [WB_WIDTH-1:0]        offset;
    logic [NODE_ADDR_WIDTH-1:0] bus_node;
    logic                       high_half;
    logic [COMP_WIDTH-1:0]      low_hold_q;
    logic [COMP_WIDTH-1:0]      rd_half;
    logic                       ack_q;
    logic [WB_WIDTH-1:0]        dat_q;

    // streaming writes only outside bus mode
    assign stream_we = load_valid_i & ~bus_mode_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt_q <= '0;
        end else if (stream_we) begin
            wr_cnt_q <= (wr_cnt_q == NODE_ADDR_WIDTH'(NUM_NODES - 1)) ? '0 : wr_cnt_q + 1'b1;
        end
    end

    // new request while the previous ack is not showing
    assign bus_req = wbs_cyc_i & wbs_stb_i & ~ack_q;

    // address decode, below-base wraps to a large offset and misses
    assign offset = wbs_adr_i - CFG_BASE;
    assign bus_node = offset[3 +: NODE_ADDR_WIDTH];
    assign high_half = offset[2];
    assign bus_ok = bus_req & bus_mode_i & (offset < CFG_SPAN);

    // low half waits here until the high half commits the node
    always_ff @(posedge clk) begin
        if (bus_ok && wbs_we_i && !high_half) begin
            low_hold_q <= wbs_dat_i[COMP_WIDTH-1:0];
        end
    end

    always_comb begin
        if (bus_mode_i) begin
            node_wr_en_o = bus_ok & wbs_we_i & high_half;
            node_wr_addr_o = bus_node;
            node_wr_data_o = {wbs_dat_i[COMP_WIDTH-1:0], low_hold_q};
        end else begin
            node_wr_en_o = stream_we;
            node_wr_addr_o = wr_cnt_q;
            node_wr_data_o = load_data_i;
        end
    end

    assign node_rd_addr_o = bus_node;
    assign rd_half = high_half ? node_rd_data_i[NODE_WIDTH-1:COMP_WIDTH]
                               : node_rd_data_i[COMP_WIDTH-1:0];

    // ack one clock after the request, read data alongside
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req;
        end
    end

    // writes and misses read as zero
    always_ff @(posedge clk) begin
        if (bus_req) begin
            dat_q <= (bus_ok && !wbs_we_i) ? WB_WIDTH'(rd_half) : '0;
        end
    end

    assign wbs_ack_o = ack_q;
    assign wbs_dat_o = dat_q;

endmodule

`default_nettype wire

/* kd_search_top.sv */
/*
 kd-tree search engine top
 node loader and two-lane pipelined search tree on one clock
*/
`timescale 1ns/1ps
`default_nettype none

module kd_search_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           bus_mode_i,
    input  wire                           load_valid_i,
    input  wire  [kd_pkg::NODE_WIDTH-1:0]  load_data_i,
    input  wire                           query_valid_i,
    input  wire  [kd_pkg::PATCH_WIDTH-1:0] query_i,
    input  wire                           query_two_valid_i,
    input  wire  [kd_pkg::PATCH_WIDTH-1:0] query_two_i,
    input  wire                           wbs_cyc_i,
    input  wire                           wbs_stb_i,
    input  wire                           wbs_we_i,
    input  wire  [kd_pkg::WB_WIDTH-1:0]    wbs_adr_i,
    input  wire  [kd_pkg::WB_WIDTH-1:0]    wbs_dat_i,
    output logic                          leaf_valid_o,
    output logic [kd_pkg::LEAF_WIDTH-1:0]  leaf_index_o,
    output logic                          leaf_two_valid_o,
    output logic [kd_pkg::LEAF_WIDTH-1:0]  leaf_two_index_o,
    output logic                          wbs_ack_o,
    output logic [kd_pkg::WB_WIDTH-1:0]    wbs_dat_o
);
    import kd_pkg::*;

    // node access between loader and tree
    logic                       node_wr_en;
    logic [NODE_ADDR_WIDTH-1:0] node_wr_addr;
    logic [NODE_WIDTH-1:0]      node_wr_data;
    logic [NODE_ADDR_WIDTH-1:0] node_rd_addr;
    logic [NODE_WIDTH-1:0]      node_rd_data;

    kd_node_loader u_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus_mode_i     (bus_mode_i),
        .load_valid_i   (load_valid_i),
        .load_data_i    (load_data_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_dat_i      (wbs_dat_i),
        .node_rd_data_i (node_rd_data),
        .wbs_ack_o      (wbs_ack_o),
        .wbs_dat_o      (wbs_dat_o),
        .node_wr_en_o   (node_wr_en),
        .node_wr_addr_o (node_wr_addr),
        .node_wr_data_o (node_wr_data),
        .node_rd_addr_o (node_rd_addr)
    );

    kd_node_tree u_tree (
        .clk               (clk),
        .rst_n             (rst_n),
        .node_wr_en_i      (node_wr_en),
        .node_wr_addr_i    (node_wr_addr),
        .node_wr_data_i    (node_wr_data),
        .node_rd_addr_i    (node_rd_addr),
        .query_valid_i     (query_valid_i),
        .query_i           (query_i),
        .query_two_valid_i (query_two_valid_i),
        .query_two_i       (query_two_i),
        .node_rd_data_o    (node_rd_data),
        .leaf_valid_o      (leaf_valid_o),
        .leaf_index_o      (leaf_index_o),
        .leaf_two_valid_o  (leaf_two_valid_o),
        .leaf_two_index_o  (leaf_two_index_o)
    );

endmodule

`default_nettype wire

/* kd_search_properties.sv */
/*
 kd-tree search engine properties
 single-cycle bus ack, fixed leaf latency per lane and known leaf
 indices, bound into the search top
*/
`timescale 1ns/1ps
`default_nettype none

module kd_search_properties (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          query_valid_i,
    input wire                          query_two_valid_i,
    input wire                          leaf_valid_o,
    input wire [kd_pkg::LEAF_WIDTH-1:0] leaf_index_o,
    input wire                          leaf_two_valid_o,
    input wire [kd_pkg::LEAF_WIDTH-1:0] leaf_two_index_o,
    input wire                          wbs_ack_o
);
    import kd_pkg::*;

    // ack never holds for two clocks
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wbs_ack_o |=> !wbs_ack_o)
        else $error("wbs_ack_o held longer than one cycle");

    // every leaf valid matches a query strobe exactly one latency back
    leaf_latency: assert property (@(posedge clk) disable iff (!rst_n)
        leaf_valid_o == $past(query_valid_i, SEARCH_LATENCY))
        else $error("leaf_valid_o out of step with query_valid_i");

    leaf_two_latency: assert property (@(posedge clk) disable iff (!rst_n)
        leaf_two_valid_o == $past(query_two_valid_i, SEARCH_LATENCY))
        else $error("leaf_two_valid_o out of step with query_two_valid_i");

    leaf_known: assert property (@(posedge clk) disable iff (!rst_n)
        (leaf_valid_o |-> !$isunknown(leaf_index_o)) and
        (leaf_two_valid_o |-> !$isunknown(leaf_two_index_o)))
        else $error("leaf index unknown while valid");

endmodule

bind kd_search_top kd_search_properties u_props (
    .clk               (clk),
    .rst_n             (rst_n),
    .query_valid_i     (query_valid_i),
    .query_two_valid_i (query_two_valid_i),
    .leaf_valid_o      (leaf_valid_o),
    .leaf_index_o      (leaf_index_o),
    .leaf_two_valid_o  (leaf_two_valid_o),
    .leaf_two_index_o  (leaf_two_index_o),
    .wbs_ack_o         (wbs_ack_o)
);

`default_nettype wire

/* tb_kd_search.sv */
/*
 kd-tree search engine testbench
 loads nodes through the streaming port and the wishbone slave, then runs
 random two-lane queries against a reference tree and checks the leaf index
 and the latency of every result
*/
`timescale 1ns/1ps
`default_nettype none

module tb_kd_search;
    import kd_pkg::*;

    localparam int ACK_TIMEOUT = 16;
    localparam int DRAIN_TIMEOUT = 32;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   bus_mode_i;
    logic                   load_valid_i;
    logic [NODE_WIDTH-1:0]  load_data_i;
    logic                   query_valid_i;
    logic [PATCH_WIDTH-1:0] query_i;
    logic                   query_two_valid_i;
    logic [PATCH_WIDTH-1:0] query_two_i;
    logic                   wbs_cyc_i;
    logic                   wbs_stb_i;
    logic                   wbs_we_i;
    logic [WB_WIDTH-1:0]    wbs_adr_i;
    logic [WB_WIDTH-1:0]    wbs_dat_i;
    logic                   leaf_valid_o;
    logic [LEAF_WIDTH-1:0]  leaf_index_o;
    logic                   leaf_two_valid_o;
    logic [LEAF_WIDTH-1:0]  leaf_two_index_o;
    logic                   wbs_ack_o;
    logic [WB_WIDTH-1:0]    wbs_dat_o;

    int errors = 0;
    int checks = 0;
    int cyc = 0;
    logic [31:0] lfsr_state = 32'd69;

    // reference tree and its own stream counter
    logic [NODE_WIDTH-1:0] model_node [NUM_NODES];
    int model_cnt = 0;

    // expected results per lane, issue cycle and leaf index side by side
    int exp_cyc_one [$];
    logic [LEAF_WIDTH-1:0] exp_idx_one [$];
    int exp_cyc_two [$];
    logic [LEAF_WIDTH-1:0] exp_idx_two [$];
    logic due_one;
    logic due_two;

    kd_search_top kd_search_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .bus_mode_i        (bus_mode_i),
        .load_valid_i      (load_valid_i),
        .load_data_i       (load_data_i),
        .query_valid_i     (query_valid_i),
        .query_i           (query_i),
        .query_two_valid_i (query_two_valid_i),
        .query_two_i       (query_two_i),
        .wbs_cyc_i         (wbs_cyc_i),
        .wbs_stb_i         (wbs_stb_i),
        .wbs_we_i          (wbs_we_i),
        .wbs_adr_i         (wbs_adr_i),
        .wbs_dat_i         (wbs_dat_i),
        .leaf_valid_o      (leaf_valid_o),
        .leaf_index_o      (leaf_index_o),
        .leaf_two_valid_o  (leaf_two_valid_o),
        .leaf_two_index_o  (leaf_two_index_o),
        .wbs_ack_o         (wbs_ack_o),
        .wbs_dat_o         (wbs_dat_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // walk the tree by the split rule, first decision lands in the msb
    function automatic logic [LEAF_WIDTH-1:0] model_leaf(input logic [PATCH_WIDTH-1:0] p);
        int n;
        int d;
        logic [LEAF_WIDTH-1:0] path;
        n = 0;
        path = '0;
        for (int l = 0; l < TREE_DEPTH; l++) begin
            d = int'(model_node[n][COMP_WIDTH +: DIM_WIDTH]);
            // out of range dims use component 0
            if (d >= NUM_DIMS) begin
                d = 0;
            end
            if (p[d*COMP_WIDTH +: COMP_WIDTH] > model_node[n][COMP_WIDTH-1:0]) begin
                path = {path[LEAF_WIDTH-2:0], 1'b1};
                n = 2 * n + 2;
            end else begin
                path = {path[LEAF_WIDTH-2:0], 1'b0};
                n = 2 * n + 1;
            end
        end
        return path;
    endfunction

    // result monitor, outputs settle long before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            due_one = (exp_cyc_one.size() > 0) && (exp_cyc_one[0] + SEARCH_LATENCY == cyc);
            due_two = (exp_cyc_two.size() > 0) && (exp_cyc_two[0] + SEARCH_LATENCY == cyc);
            check("leaf_valid_o", 32'(leaf_valid_o), 32'(due_one));
            check("leaf_two_valid_o", 32'(leaf_two_valid_o), 32'(due_two));
            if (due_one) begin
                check("leaf_index_o", 32'(leaf_index_o), 32'(exp_idx_one[0]));
                void'(exp_cyc_one.pop_front());
                void'(exp_idx_one.pop_front());
            end
            if (due_two) begin
                check("leaf_two_index_o", 32'(leaf_two_index_o), 32'(exp_idx_two[0]));
                void'(exp_cyc_two.pop_front());
                void'(exp_idx_two.pop_front());
            end
        end
    end

    function automatic logic [31:0] half_addr(input int n, input int hi);
        return CFG_BASE + 32'(NODE_STRIDE * n + 4 * hi);
    endfunction

    // single wishbone access, returns the data seen with ack
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i = we;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        @(negedge clk);
        while (!wbs_ack_o) begin
            if (waited == ACK_TIMEOUT) begin
                errors++;
                $display("timeout: no wbs_ack_o for the bus access at address %h", adr);
                finish_run();
            end
            waited++;
            @(negedge clk);
        end
        // ack belongs on the first clock after the request
        check("wbs_ack_o delay", 32'(waited), 32'd0);
        rdat = wbs_dat_o;
        // strobe stays up over the clock that samples ack
        @(negedge clk);
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i = 1'b0;
    endtask

    task automatic read_check(input logic [31:0] adr, input logic [31:0] exp);
        logic [31:0] rdat;
        bus_cycle(1'b0, adr, '0, rdat);
        check($sformatf("wbs_dat_o@%h", adr), rdat, exp);
    endtask

    // writes always read back zero
    task automatic write_check(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] rdat;
        bus_cycle(1'b1, adr, wdat, rdat);
        check($sformatf("wbs_dat_o@%h", adr), rdat, 32'd0);
    endtask

    task automatic verify_nodes();
        for (int n = 0; n < NUM_NODES; n++) begin
            read_check(half_addr(n, 0), 32'(model_node[n][COMP_WIDTH-1:0]));
            read_check(half_addr(n, 1), 32'(model_node[n][NODE_WIDTH-1:COMP_WIDTH]));
        end
    endtask

    // low then high, upper data bits carry junk
    task automatic bus_write_node(input int n);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = 32'(rand_bits(32));
        hi = 32'(rand_bits(32));
        write_check(half_addr(n, 0), lo);
        write_check(half_addr(n, 1), hi);
        if (bus_mode_i) begin
            model_node[n] = {hi[COMP_WIDTH-1:0], lo[COMP_WIDTH-1:0]};
        end
    endtask

    task automatic stream_nodes(input int count);
        logic [NODE_WIDTH-1:0] d;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            d = NODE_WIDTH'(rand_bits(NODE_WIDTH));
            load_valid_i = 1'b1;
            load_data_i = d;
            if (!bus_mode_i) begin
                model_node[model_cnt] = d;
                model_cnt = (model_cnt == NUM_NODES - 1) ? 0 : model_cnt + 1;
            end
        end
        @(negedge clk);
        load_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_cyc_one.size() + exp_cyc_two.size() > 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                errors++;
                $display("timeout: expected leaf results never came out of the tree");
                finish_run();
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // about three busy cycles in four per lane, runs and gaps fall out of that
    task automatic run_queries(input int count);
        logic [PATCH_WIDTH-1:0] p;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            p = PATCH_WIDTH'(rand_bits(PATCH_WIDTH));
            query_valid_i = |rand_bits(2);
            query_i = p;
            if (query_valid_i) begin
                exp_cyc_one.push_back(cyc);
                exp_idx_one.push_back(model_leaf(p));
            end
            p = PATCH_WIDTH'(rand_bits(PATCH_WIDTH));
            query_two_valid_i = |rand_bits(2);
            query_two_i = p;
            if (query_two_valid_i) begin
                exp_cyc_two.push_back(cyc);
                exp_idx_two.push_back(model_leaf(p));
            end
        end
        @(negedge clk);
        query_valid_i = 1'b0;
        query_two_valid_i = 1'b0;
        wait_drain();
    endtask

    initial begin
        rst_n = 1'b0;
        bus_mode_i = 1'b0;
        load_valid_i = 1'b0;
        load_data_i = '0;
        query_valid_i = 1'b0;
        query_i = '0;
        query_two_valid_i = 1'b0;
        query_two_i = '0;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i = 1'b0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            model_node[n] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset, every node empty
        check("wbs_ack_o", 32'(wbs_ack_o), 32'd0);
        bus_mode_i = 1'b1;
        verify_nodes();

        // streaming load of the whole tree
        bus_mode_i = 1'b0;
        stream_nodes(NUM_NODES);
        bus_mode_i = 1'b1;
        verify_nodes();
        run_queries(300);

        // bus writes over the streamed tree
        repeat (40) bus_write_node(int'(rand_bits(6)) % NUM_NODES);
        verify_nodes();
        run_queries(200);

        // stream in bus mode and bus writes outside it change nothing
        stream_nodes(10);
        bus_mode_i = 1'b0;
        repeat (8) bus_write_node(int'(rand_bits(6)) % NUM_NODES);
        read_check(half_addr(5, 0), 32'd0);
        read_check(half_addr(9, 1), 32'd0);
        bus_mode_i = 1'b1;
        // outside the node map
        write_check(half_addr(NUM_NODES, 0), 32'(rand_bits(32)));
        write_check(half_addr(NUM_NODES, 1), 32'(rand_bits(32)));
        read_check(half_addr(NUM_NODES, 1), 32'd0);
        read_check(CFG_BASE - 32'd4, 32'd0);
        verify_nodes();

        // 70 more words wrap the counter onto nodes 0..6
        bus_mode_i = 1'b0;
        stream_nodes(70);
        bus_mode_i = 1'b1;
        verify_nodes();
        run_queries(100);

        finish_run();
    end

endmodule

`default_nettype wire

/* tb.f */
kd_pkg.sv
kd_internal_node.sv
kd_node_tree.sv
kd_node_loader.sv
kd_search_top.sv
kd_search_properties.sv
tb_kd_search.sv

/* Makefile */
# verilator build and run of the kd-tree search testbench

SIM = obj_dir/Vtb_kd_search
SRCS = $(shell cat tb.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_kd_search -Mdir obj_dir -f tb.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 ; cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
